/* sim/axi_line_master_input.txt */
// Columns: opcode (0 nop, 1 read, 2 write), byte address, line data in hex.
// Write rows carry the line to send, read rows the line expected back.
2 00001000 1700010716000106150001051400010413000103120001021100010110000100
2 00001020 2700020726000206250002052400020423000203220002022100020120000200
2 00001040 3700030736000306350003053400030433000303320003023100030130000300
0 00000000 0
2 00001060 4700040746000406450004054400040443000403420004024100040140000400
2 00001080 5700050756000506550005055400050453000503520005025100050150000500
2 000010a0 6700060766000606650006056400060463000603620006026100060160000600
1 00001000 1700010716000106150001051400010413000103120001021100010110000100
1 00001020 2700020726000206250002052400020423000203220002022100020120000200
1 00001040 3700030736000306350003053400030433000303320003023100030130000300
1 00001060 4700040746000406450004054400040443000403420004024100040140000400
1 00001080 5700050756000506550005055400050453000503520005025100050150000500
1 000010a0 6700060766000606650006056400060463000603620006026100060160000600
2 00002000 deadbeefcafef00d0123456789abcdeffedcba9876543210a5a5a5a55a5a5a5a
2 00001000 8700080786000806850008058400080483000803820008028100080180000800
0 00000000 0
1 00002000 deadbeefcafef00d0123456789abcdeffedcba9876543210a5a5a5a55a5a5a5a
1 00001000 8700080786000806850008058400080483000803820008028100080180000800

/* axi_line_master.f */
+incdir+hdl
hdl/axi_line_master_pkg.sv
hdl/txn_if.sv
hdl/sync_fifo.sv
hdl/burst_issue.sv
hdl/line_collect.sv
hdl/axi_line_master.sv
sim/axi_line_master_asserts.sv
sim/axi_line_master_tb.sv

/* Bender.yml */
package:
  name: axi_line_master

export_include_dirs:
  - hdl

sources:
  - hdl/axi_line_master_pkg.sv
  - hdl/txn_if.sv
  - hdl/sync_fifo.sv
  - hdl/burst_issue.sv
  - hdl/line_collect.sv
  - hdl/axi_line_master.sv
  - target: simulation
    files:
      - sim/axi_line_master_asserts.sv
      - sim/axi_line_master_tb.sv

/* sim/axi_line_master_tb.sv */
////////////////////////////////////////
// AXI line master testbench.
// File-driven line requests, a random-stall AXI slave memory
// and checks on bursts and returned lines.
////////////////////////////////////////
`timescale 1ns/1ps
`include "axi_line_master_defs.svh"

module axi_line_master_tb;

  import axi_line_master_pkg::*;

  localparam int MAX_REQ        = 32;   // Rows the stimulus memory can hold.
  localparam int CYCLES_PER_REQ = 400;  // Timeout budget per input row.
  localparam int HOLD_CYCLES    = 40;   // Extra cycles with the line port blocked.

  localparam logic [3:0] EXP_ID    = 4'h3;   // Fixed AXI fields of every burst.
  localparam logic [7:0] EXP_LEN   = 8'd7;   // Eight beats.
  localparam logic [2:0] EXP_SIZE  = 3'd2;   // 4-byte beats.
  localparam logic [1:0] EXP_BURST = 2'b01;  // INCR.

  logic                     aclk = 1'b0;
  logic                     aresetn = 1'b0;
  logic [`AXI_ADDR_W-1:0]   ls_address = '0;
  ls_op_e                   ls_operation = OP_NOP;
  logic [`LINE_W-1:0]       ls_data_in = '0;
  logic                     ls_valid_in = 1'b0;
  logic                     ls_ready_out;
  logic [`LINE_W-1:0]       ls_data_out;
  logic                     ls_valid_out;
  logic                     ls_ready_in = 1'b0;
  logic [`AXI_ID_W-1:0]     awid;
  logic [`AXI_ADDR_W-1:0]   awaddr;
  logic [7:0]               awlen;
  logic [2:0]               awsize;
  logic [1:0]               awburst;
  logic                     awvalid;
  logic                     awready = 1'b0;
  logic [`AXI_DATA_W-1:0]   wdata;
  logic [`AXI_DATA_W/8-1:0] wstrb;
  logic                     wlast;
  logic                     wvalid;
  logic                     wready = 1'b0;
  logic                     bvalid = 1'b0;
  logic                     bready;
  logic [`AXI_ID_W-1:0]     arid;
  logic [`AXI_ADDR_W-1:0]   araddr;
  logic [7:0]               arlen;
  logic [2:0]               arsize;
  logic [1:0]               arburst;
  logic                     arvalid;
  logic                     arready = 1'b0;
  logic [`AXI_DATA_W-1:0]   rdata = '0;
  logic                     rlast = 1'b0;
  logic                     rvalid = 1'b0;
  logic                     rready;

  logic [`LINE_W-1:0]     stim_mem [MAX_REQ*3];  // Opcode, address, line per row.
  logic [`AXI_DATA_W-1:0] mem [logic [`AXI_ADDR_W-1:0]];  // Slave memory, byte address.
  ls_op_e                 exp_op_q [$];    // Bursts still to appear on AXI.
  logic [`AXI_ADDR_W-1:0] exp_addr_q [$];
  logic [`LINE_W-1:0]     exp_line_q [$];
  logic [`LINE_W-1:0]     ret_line_q [$];  // Lines still to come out.
  logic [`LINE_W-1:0]     cur_wline;       // Line of the open write burst.
  logic [`AXI_ADDR_W-1:0] w_addr;
  logic [`AXI_ADDR_W-1:0] r_addr;
  integer                 seed = 32'h2d26_bf05;
  int                     n_req = 0;
  int                     err_cnt = 0;
  int                     cycle_cnt = 0;
  int                     wr_acc = 0;       // Writes accepted at the line port.
  int                     rd_acc = 0;
  int                     aw_cnt = 0;
  int                     ar_cnt = 0;
  int                     b_cnt = 0;
  int                     lines_taken = 0;
  int                     w_beat = 0;
  int                     r_beat = 0;
  bit                     w_open = 1'b0;
  bit                     b_pend = 1'b0;
  bit                     r_busy = 1'b0;
  bit                     hold_ret = 1'b1;  // Line port blocked while set.

  axi_line_master uut (.*);

  always #50 aclk = ~aclk;  // 100 ns period.

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic report_mismatch(input string name, input logic [`LINE_W-1:0] got,
                                 input logic [`LINE_W-1:0] exp);
    $display("mismatch %s: got %0h expected %0h", name, got, exp);
    err_cnt++;
  endtask

  // Three in four cycles ready.
  function automatic bit chance_ready();
    return ($random(seed) & 3) != 0;
  endfunction

  // Unwritten words return a pattern of their address.
  function automatic logic [`AXI_DATA_W-1:0] read_word(input logic [`AXI_ADDR_W-1:0] addr);
    if (mem.exists(addr)) return mem[addr];
    return addr ^ 32'h5a5a_a5a5;
  endfunction

  // Queue what an accepted row must cause downstream.
  task automatic record_request(input int row);
    ls_op_e op;
    op = ls_op_e'(stim_mem[3*row][1:0]);
    if (op == OP_WRITE || op == OP_READ) begin
      exp_op_q.push_back(op);
      exp_addr_q.push_back(stim_mem[3*row+1][`AXI_ADDR_W-1:0]);
      exp_line_q.push_back(stim_mem[3*row+2]);
    end
    if (op == OP_WRITE) wr_acc++;
    if (op == OP_READ) begin
      ret_line_q.push_back(stim_mem[3*row+2]);  // Expected read line.
      rd_acc++;
    end
  endtask

  // Address handshake against the oldest pending request.
  task automatic take_burst(input ls_op_e op, input string ch, input logic [3:0] id,
                            input logic [7:0] len, input logic [2:0] size,
                            input logic [1:0] burst, input logic [31:0] addr);
    if (exp_op_q.size() == 0) begin
      $display("%s handshake with no request waiting for it", ch);
      err_cnt++;
    end else begin
      if (exp_op_q[0] != op) begin
        $display("%s handshake for a request of the other kind", ch);
        err_cnt++;
      end
      if (addr !== exp_addr_q[0]) report_mismatch({ch, "addr"}, addr, exp_addr_q[0]);
      cur_wline = exp_line_q[0];
      void'(exp_op_q.pop_front());
      void'(exp_addr_q.pop_front());
      void'(exp_line_q.pop_front());
    end
    if (id !== EXP_ID) report_mismatch({ch, "id"}, id, EXP_ID);
    if (len !== EXP_LEN) report_mismatch({ch, "len"}, len, EXP_LEN);
    if (size !== EXP_SIZE) report_mismatch({ch, "size"}, size, EXP_SIZE);
    if (burst !== EXP_BURST) report_mismatch({ch, "burst"}, burst, EXP_BURST);
  endtask

  ////////////////////////////////////////
  // AXI slave memory model
  ////////////////////////////////////////

  always @(posedge aclk) begin
    if (!aresetn) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      arready <= 1'b0;
      bvalid  <= 1'b0;
      rvalid  <= 1'b0;
      rlast   <= 1'b0;
      w_open  = 1'b0;
      b_pend  = 1'b0;
      r_busy  = 1'b0;
    end else begin
      awready <= chance_ready();  // Random stalls on every channel.
      wready  <= chance_ready();
      arready <= chance_ready();
      if (awvalid && awready) begin
        aw_cnt++;
        take_burst(OP_WRITE, "aw", awid, awlen, awsize, awburst, awaddr);
        w_addr = awaddr;
        w_beat = 0;
        w_open = 1'b1;
      end
      if (wvalid && wready) begin
        if (!w_open) begin
          $display("W beat arrived with no open write burst");
          err_cnt++;
        end
        if (wstrb !== '1) report_mismatch("wstrb", wstrb, {(`AXI_DATA_W/8){1'b1}});
        if (wdata !== cur_wline[32*w_beat +: 32])
          report_mismatch("wdata", wdata, cur_wline[32*w_beat +: 32]);
        if (wlast !== (w_beat == `BEATS - 1))
          report_mismatch("wlast", wlast, (w_beat == `BEATS - 1));
        mem[w_addr + 32'(4*w_beat)] = wdata;
        w_beat++;
        if (wlast) begin
          w_open = 1'b0;
          b_pend = 1'b1;  // Response owed.
        end
      end
      if (bvalid && bready) begin
        bvalid <= 1'b0;
        b_cnt++;
      end else if (b_pend && !bvalid && chance_ready()) begin
        bvalid <= 1'b1;
        b_pend = 1'b0;
      end
      if (arvalid && arready) begin
        take_burst(OP_READ, "ar", arid, arlen, arsize, arburst, araddr);
        r_addr = araddr;
        r_beat = 0;
        r_busy = 1'b1;
      end
      if (rvalid && rready) begin
        rvalid <= 1'b0;
        rlast  <= 1'b0;
        r_beat++;
        if (r_beat == `BEATS) r_busy = 1'b0;
      end
      // Next beat only once the current one is taken.
      if (r_busy && (!rvalid || rready) && chance_ready()) begin
        rvalid <= 1'b1;
        rdata  <= read_word(r_addr + 32'(4*r_beat));
        rlast  <= (r_beat == `BEATS - 1);
      end
    end
  end

  always @(posedge aclk) begin
    if (!aresetn) ls_ready_in <= 1'b0;
    else          ls_ready_in <= !hold_ret && chance_ready();
  end

  ////////////////////////////////////////
  // Line port monitor and credit check
  ////////////////////////////////////////

  always @(posedge aclk) begin
    if (aresetn) begin
      if (arvalid && arready) ar_cnt++;
      if (ls_valid_out && ls_ready_in) begin
        if (ret_line_q.size() == 0) begin
          $display("line returned with no read waiting for it");
          err_cnt++;
        end else begin
          if (ls_data_out !== ret_line_q[0])
            report_mismatch("ls_data_out", ls_data_out, ret_line_q[0]);
          void'(ret_line_q.pop_front());
        end
        lines_taken++;
      end
      if (ar_cnt - lines_taken > `RET_DEPTH) begin
        $display("more reads issued than free return slots");
        err_cnt++;
      end
    end
  end

  // Block the line port until the return FIFO is full, then release it.
  initial begin : hold_return
    int ar_at_hold;
    wait (aresetn === 1'b1);
    @(negedge aclk);
    while (ar_cnt - lines_taken < `RET_DEPTH) @(negedge aclk);
    ar_at_hold = ar_cnt;
    repeat (HOLD_CYCLES) @(negedge aclk);
    if (ar_cnt != ar_at_hold) report_mismatch("ar_count", ar_cnt, ar_at_hold);
    hold_ret = 1'b0;
  end

  always @(posedge aclk) begin
    cycle_cnt++;
    if (n_req > 0 && cycle_cnt >= CYCLES_PER_REQ * n_req) begin
      $display("Timeout after %0d cycles with %0d errors", cycle_cnt, err_cnt);
      $display("Test failures found");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    $readmemh("sim/axi_line_master_input.txt", stim_mem);
    while (n_req < MAX_REQ && stim_mem[3*n_req] !== 'x) n_req++;  // Rows in the file.
    if (n_req == 0) begin
      $display("stimulus file holds no requests");
      err_cnt++;
    end
    repeat (3) @(posedge aclk);
    aresetn <= 1'b1;
    @(negedge aclk);
    if (awvalid !== 1'b0) report_mismatch("awvalid", awvalid, 1'b0);
    if (wvalid !== 1'b0) report_mismatch("wvalid", wvalid, 1'b0);
    if (arvalid !== 1'b0) report_mismatch("arvalid", arvalid, 1'b0);
    if (bready !== 1'b0) report_mismatch("bready", bready, 1'b0);
    if (rready !== 1'b0) report_mismatch("rready", rready, 1'b0);
    if (ls_valid_out !== 1'b0) report_mismatch("ls_valid_out", ls_valid_out, 1'b0);
    @(posedge aclk);
    for (int i = 0; i < n_req; i++) begin
      ls_valid_in  <= 1'b1;
      ls_operation <= ls_op_e'(stim_mem[3*i][1:0]);
      ls_address   <= stim_mem[3*i+1][`AXI_ADDR_W-1:0];
      ls_data_in   <= stim_mem[3*i+2];
      @(posedge aclk);
      while (!ls_ready_out) @(posedge aclk);  // Accepted on this edge.
      record_request(i);
    end
    ls_valid_in <= 1'b0;
    while (exp_op_q.size() != 0 || ret_line_q.size() != 0 || b_cnt != wr_acc)
      @(posedge aclk);
    if (aw_cnt != wr_acc) report_mismatch("aw_count", aw_cnt, wr_acc);
    if (ar_cnt != rd_acc) report_mismatch("ar_count", ar_cnt, rd_acc);
    $display("Summary: %0d errors, %0d writes, %0d reads, %0d lines returned",
             err_cnt, aw_cnt, ar_cnt, lines_taken);
    if (err_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* sim/axi_line_master_asserts.sv */
////////////////////////////////////////
// Protocol checks for both stages.
// Valid held until ready, eight-beat bursts, credit bound.
////////////////////////////////////////
`timescale 1ns/1ps
`include "axi_line_master_defs.svh"

module axi_line_master_asserts (
  input logic                 aclk,
  input logic                 aresetn,
  input logic                 vld_a,      // First valid/ready pair.
  input logic                 rdy_a,
  input logic                 vld_b,      // Second valid/ready pair.
  input logic                 rdy_b,
  input logic                 beat_hs,    // Data beat accepted.
  input logic                 beat_last,
  input logic [`CREDIT_W-1:0] level       // Credits, or return FIFO fill plus a pending push.
);

  logic [`BEAT_IDX_W-1:0] beat_cnt;

  always_ff @(posedge aclk) begin
    if (!aresetn)     beat_cnt <= '0;
    else if (beat_hs) beat_cnt <= beat_cnt + 1'b1;  // Wraps after eight beats.
  end

  a_hold_stable: assert property (@(posedge aclk) disable iff (!aresetn)
    vld_a && !rdy_a |=> vld_a)
    else $error("first valid dropped before its ready");

  b_hold_stable: assert property (@(posedge aclk) disable iff (!aresetn)
    vld_b && !rdy_b |=> vld_b)
    else $error("second valid dropped before its ready");

  last_on_eighth: assert property (@(posedge aclk) disable iff (!aresetn)
    beat_hs |-> (beat_last == (beat_cnt == `BEAT_IDX_W'(`BEATS - 1))))
    else $error("last flag not on the eighth beat");

  level_bound: assert property (@(posedge aclk) disable iff (!aresetn)
    level <= `CREDIT_W'(`RET_DEPTH))
    else $error("level above the return FIFO depth");

endmodule

bind burst_issue axi_line_master_asserts u_issue_chk (
  .aclk      (aclk),
  .aresetn   (aresetn),
  .vld_a     (awvalid),
  .rdy_a     (awready),
  .vld_b     (arvalid),
  .rdy_b     (arready),
  .beat_hs   (wvalid && wready),
  .beat_last (wlast),
  .level     (credit_cnt)
);

bind line_collect axi_line_master_asserts u_collect_chk (
  .aclk      (aclk),
  .aresetn   (aresetn),
  .vld_a     (ls_valid_out),
  .rdy_a     (ls_ready_in),
  .vld_b     (bvalid),
  .rdy_b     (bready),
  .beat_hs   (rvalid && rready),
  .beat_last (rlast),
  .level     (u_ret_fifo.count + ret_push)
);

/* hdl/axi_line_master.sv */
////////////////////////////////////////
// AXI4 line master, top level.
// 256-bit line requests in, 8-beat INCR bursts out,
// read lines back in request order.
////////////////////////////////////////
`timescale 1ns/1ps
`include "axi_line_master_defs.svh"

module axi_line_master (
  input  logic                         aclk,
  input  logic                         aresetn,
  // Line request and return ports.
  input  logic [`AXI_ADDR_W-1:0]       ls_address,
  input  axi_line_master_pkg::ls_op_e  ls_operation,
  input  logic [`LINE_W-1:0]           ls_data_in,
  input  logic                         ls_valid_in,
  output logic                         ls_ready_out,
  output logic [`LINE_W-1:0]           ls_data_out,
  output logic                         ls_valid_out,
  input  logic                         ls_ready_in,
  // AXI4 write address, data and response.
  output logic [`AXI_ID_W-1:0]         awid,
  output logic [`AXI_ADDR_W-1:0]       awaddr,
  output logic [7:0]                   awlen,
  output logic [2:0]                   awsize,
  output logic [1:0]                   awburst,
  output logic                         awvalid,
  input  logic                         awready,
  output logic [`AXI_DATA_W-1:0]       wdata,
  output logic [`AXI_DATA_W/8-1:0]     wstrb,
  output logic                         wlast,
  output logic                         wvalid,
  input  logic                         wready,
  input  logic                         bvalid,
  output logic                         bready,
  // AXI4 read address and data.
  output logic [`AXI_ID_W-1:0]         arid,
  output logic [`AXI_ADDR_W-1:0]       araddr,
  output logic [7:0]                   arlen,
  output logic [2:0]                   arsize,
  output logic [1:0]                   arburst,
  output logic                         arvalid,
  input  logic                         arready,
  input  logic [`AXI_DATA_W-1:0]       rdata,
  input  logic                         rlast,
  input  logic                         rvalid,
  output logic                         rready
);

  import axi_line_master_pkg::*;

  localparam int REQ_W = `LINE_W + `AXI_ADDR_W + 2;  // Line, address, opcode.

  logic [REQ_W-1:0] req_head;
  logic             req_full;
  logic             req_empty;
  logic             req_pop;

  txn_if txn ();

  ////////////////////////////////////////
  // Request FIFO
  ////////////////////////////////////////

  sync_fifo #(
    .WIDTH (REQ_W),
    .DEPTH (`REQ_DEPTH)
  ) u_req_fifo (
    .aclk    (aclk),
    .aresetn (aresetn),
    .push    (ls_valid_in && ls_ready_out),
    .din     ({ls_data_in, ls_address, ls_operation}),
    .full    (req_full),
    .pop     (req_pop),
    .dout    (req_head),
    .empty   (req_empty)
  );

  assign ls_ready_out = !req_full;

  burst_issue u_issue (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .req_empty (req_empty),
    .req_op    (ls_op_e'(req_head[1:0])),
    .req_addr  (req_head[`AXI_ADDR_W+1:2]),
    .req_line  (req_head[REQ_W-1:`AXI_ADDR_W+2]),
    .req_pop   (req_pop),
    .awvalid   (awvalid),
    .awready   (awready),
    .awaddr    (awaddr),
    .wvalid    (wvalid),
    .wready    (wready),
    .wdata     (wdata),
    .wlast     (wlast),
    .arvalid   (arvalid),
    .arready   (arready),
    .araddr    (araddr),
    .txn       (txn.issuer)
  );

  line_collect u_collect (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .bvalid       (bvalid),
    .bready       (bready),
    .rvalid       (rvalid),
    .rready       (rready),
    .rdata        (rdata),
    .rlast        (rlast),
    .ls_data_out  (ls_data_out),
    .ls_valid_out (ls_valid_out),
    .ls_ready_in  (ls_ready_in),
    .txn          (txn.collector)
  );

  // Fixed burst shape on both address channels.
  assign awid    = `AXI_ID;
  assign awlen   = `AXI_LEN;
  assign awsize  = `AXI_SIZE;
  assign awburst = BURST_INCR;
  assign arid    = `AXI_ID;
  assign arlen   = `AXI_LEN;
  assign arsize  = `AXI_SIZE;
  assign arburst = BURST_INCR;
  assign wstrb   = '1;  // Whole beats only.

endmodule

/* hdl/line_collect.sv */
////////////////////////////////////////
// Return stage.
// Takes B and R, assembles read beats into lines
// and queues them for the line port.
////////////////////////////////////////
`timescale 1ns/1ps
`include "axi_line_master_defs.svh"

module line_collect (
  input  logic                   aclk,
  input  logic                   aresetn,
  input  logic                   bvalid,
  output logic                   bready,
  input  logic                   rvalid,
  output logic                   rready,
  input  logic [`AXI_DATA_W-1:0] rdata,
  input  logic                   rlast,
  output logic [`LINE_W-1:0]     ls_data_out,
  output logic                   ls_valid_out,
  input  logic                   ls_ready_in,
  txn_if.collector               txn
);

  logic                   b_hs;
  logic                   r_hs;
  logic                   r_end;     // Last beat accepted.
  logic [`BEAT_IDX_W-1:0] r_idx;     // Slot of the next beat.
  logic [`LINE_W-1:0]     line_q;    // Line under assembly.
  logic                   ret_push;
  logic                   ret_pop;
  logic                   ret_empty;

  assign b_hs  = bvalid && bready;
  assign r_hs  = rvalid && rready;
  assign r_end = r_hs && rlast;

  // Readies follow the open flags a cycle late.
  // Dropped straight after the closing handshake.
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      bready   <= 1'b0;
      rready   <= 1'b0;
      r_idx    <= '0;
      ret_push <= 1'b0;
    end else begin
      bready   <= txn.wr_open && !b_hs;
      rready   <= txn.rd_open && !r_end;
      ret_push <= r_end;                       // Push one cycle after RLAST.
      if (r_hs) r_idx <= rlast ? '0 : r_idx + 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (r_hs) line_q[r_idx*`AXI_DATA_W +: `AXI_DATA_W] <= rdata;  // Beat n to bits 32n up.
  end

  ////////////////////////////////////////
  // Return FIFO
  ////////////////////////////////////////

  // Never full here, the request stage holds one credit per slot.
  sync_fifo #(
    .WIDTH (`LINE_W),
    .DEPTH (`RET_DEPTH)
  ) u_ret_fifo (
    .aclk    (aclk),
    .aresetn (aresetn),
    .push    (ret_push),
    .din     (line_q),
    .full    (),
    .pop     (ret_pop),
    .dout    (ls_data_out),
    .empty   (ret_empty)
  );

  assign ls_valid_out   = !ret_empty;
  assign ret_pop        = ls_valid_out && ls_ready_in;
  assign txn.credit_ret = ret_pop;            // Slot freed.
  assign txn.done       = b_hs || r_end;      // Burst finished.

endmodule

/* hdl/burst_issue.sv */
////////////////////////////////////////
// Request stage.
// Issues AW/W or AR bursts from the request FIFO head, one at a time,
// and holds the return credits.
////////////////////////////////////////
`timescale 1ns/1ps
`include "axi_line_master_defs.svh"

module burst_issue (
  input  logic                        aclk,
  input  logic                        aresetn,
  input  logic                        req_empty,
  input  axi_line_master_pkg::ls_op_e req_op,
  input  logic [`AXI_ADDR_W-1:0]      req_addr,
  input  logic [`LINE_W-1:0]          req_line,
  output logic                        req_pop,
  output logic                        awvalid,
  input  logic                        awready,
  output logic [`AXI_ADDR_W-1:0]      awaddr,
  output logic                        wvalid,
  input  logic                        wready,
  output logic [`AXI_DATA_W-1:0]      wdata,
  output logic                        wlast,
  output logic                        arvalid,
  input  logic                        arready,
  output logic [`AXI_ADDR_W-1:0]      araddr,
  txn_if.issuer                       txn
);

  import axi_line_master_pkg::*;

  issue_state_e           state;
  issue_state_e           state_nxt;
  ls_op_e                 op_q;        // Opcode of the burst in flight.
  logic [`AXI_ADDR_W-1:0] addr_q;
  logic [`LINE_W-1:0]     line_q;      // Write line being split.
  logic [`BEAT_IDX_W-1:0] beat_idx;
  logic [`CREDIT_W-1:0]   credit_cnt;  // Free return slots.
  logic                   is_write;
  logic                   start;
  logic                   drop;
  logic                   aw_hs;
  logic                   w_hs;
  logic                   ar_hs;

  ////////////////////////////////////////
  // Head decode
  ////////////////////////////////////////

  // Reads need a free return slot.
  assign start = (state == ST_IDLE) && !req_empty &&
                 ((req_op == OP_WRITE) || (req_op == OP_READ && credit_cnt != '0));
  // NOP and unused codes are popped without a burst.
  assign drop  = (state == ST_IDLE) && !req_empty &&
                 (req_op != OP_WRITE) && (req_op != OP_READ);

  assign is_write = (op_q == OP_WRITE);
  assign aw_hs    = awvalid && awready;
  assign w_hs     = wvalid && wready;
  assign ar_hs    = arvalid && arready;
  assign req_pop  = drop || aw_hs || ar_hs;  // Head leaves on the address handshake.

  ////////////////////////////////////////
  // FSM
  ////////////////////////////////////////

  always_comb begin
    state_nxt = state;
    unique case (state)
      ST_IDLE: if (start) state_nxt = ST_ADDR;
      ST_ADDR: begin
        if (aw_hs)      state_nxt = ST_DATA;
        else if (ar_hs) state_nxt = ST_WAIT;  // No data phase for reads.
      end
      ST_DATA: if (w_hs && wlast) state_nxt = ST_WAIT;
      ST_WAIT: if (txn.done) state_nxt = ST_IDLE;
      default: state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) state <= ST_IDLE;
    else          state <= state_nxt;
  end

  // Request captured as the FSM leaves IDLE.
  always_ff @(posedge aclk) begin
    if (start) begin
      op_q   <= req_op;
      addr_q <= req_addr;
      line_q <= req_line;
    end
  end

  ////////////////////////////////////////
  // Beat index and credits
  ////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      beat_idx   <= '0;
      credit_cnt <= `CREDIT_W'(`RET_DEPTH);  // Return FIFO starts empty.
    end else begin
      if (w_hs) beat_idx <= wlast ? '0 : beat_idx + 1'b1;
      if (ar_hs && !txn.credit_ret)      credit_cnt <= credit_cnt - 1'b1;
      else if (txn.credit_ret && !ar_hs) credit_cnt <= credit_cnt + 1'b1;
    end
  end

  // AXI outputs, all decoded from registers.
  assign awvalid = (state == ST_ADDR) && is_write;
  assign arvalid = (state == ST_ADDR) && !is_write;
  assign awaddr  = addr_q;
  assign araddr  = addr_q;
  assign wvalid  = (state == ST_DATA);
  assign wdata   = line_q[beat_idx*`AXI_DATA_W +: `AXI_DATA_W];  // Beat n is bits 32n up.
  assign wlast   = (beat_idx == `BEAT_IDX_W'(`BEATS - 1));

  assign txn.wr_open = ((state == ST_DATA) || (state == ST_WAIT)) && is_write;
  assign txn.rd_open = (state == ST_WAIT) && !is_write;

endmodule

/* hdl/sync_fifo.sv */
////////////////////////////////////////
// Synchronous FIFO.
// Circular buffer with read and write pointers and a fill count.
////////////////////////////////////////
`timescale 1ns/1ps

module sync_fifo #(
  parameter int WIDTH = 32,
  parameter int DEPTH = 4
) (
  input  logic             aclk,
  input  logic             aresetn,
  input  logic             push,
  input  logic [WIDTH-1:0] din,
  output logic             full,
  input  logic             pop,
  output logic [WIDTH-1:0] dout,
  output logic             empty
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];  // Storage.
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;        // Entries held.
  logic             do_push;
  logic             do_pop;

  assign do_pop  = pop && !empty;            // Pop on empty is ignored.
  assign do_push = push && (!full || do_pop); // Push on full is fine with a pop.

  always_ff @(posedge aclk) begin
    if (do_push) mem[wr_ptr] <= din;
  end

  // Pointers wrap at DEPTH, so any depth works.
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)  rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (do_push && !do_pop)      count <= count + 1'b1;
      else if (do_pop && !do_push) count <= count - 1'b1;
    end
  end

  assign dout  = mem[rd_ptr];              // Head entry.
  assign full  = (count == CNT_W'(DEPTH));
  assign empty = (count == '0);

endmodule

/* hdl/txn_if.sv */
////////////////////////////////////////
// Transaction link between the stages.
// Completion and credit pulses back, open flags forward.
////////////////////////////////////////
`timescale 1ns/1ps

interface txn_if;

  // Collector to issuer.
  logic done;        // Pulse on B handshake or last R handshake.
  logic credit_ret;  // Pulse when a line leaves the return FIFO.

  // Issuer to collector.
  logic rd_open;     // Read outstanding.
  logic wr_open;     // Write outstanding.

  modport issuer (
    input  done,
    input  credit_ret,
    output rd_open,
    output wr_open
  );

  modport collector (
    output done,
    output credit_ret,
    input  rd_open,
    input  wr_open
  );

endinterface

/* hdl/axi_line_master_pkg.sv */
////////////////////////////////////////
// AXI line master types.
// Request opcodes, AXI burst kinds and issue FSM states.
////////////////////////////////////////
package axi_line_master_pkg;

  // Request opcode from the line port.
  typedef enum logic [1:0] {
    OP_NOP   = 2'd0,  // Dropped by the request stage.
    OP_READ  = 2'd1,
    OP_WRITE = 2'd2
  } ls_op_e;

  // AXI AxBURST encoding.
  typedef enum logic [1:0] {
    BURST_FIXED = 2'd0,
    BURST_INCR  = 2'd1,  // The only kind issued here.
    BURST_WRAP  = 2'd2
  } burst_e;

  // Request stage FSM.
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,  // Waiting for a request.
    ST_ADDR = 2'd1,  // AW or AR valid.
    ST_DATA = 2'd2,  // Write beats on W.
    ST_WAIT = 2'd3   // Waiting for B or last R.
  } issue_state_e;

endpackage

/* hdl/axi_line_master_defs.svh */
////////////////////////////////////////
// AXI line master constants.
// Bus widths, FIFO depths and the fixed AXI burst fields.
////////////////////////////////////////
`ifndef AXI_LINE_MASTER_DEFS_SVH
`define AXI_LINE_MASTER_DEFS_SVH

`define AXI_ADDR_W 32   // Address width.
`define AXI_DATA_W 32   // One beat.
`define LINE_W     256  // One cache line.
`define BEATS      8    // Beats per line.
`define BEAT_IDX_W 3    // Beat counter width.

`define AXI_ID_W 4      // Transaction ID width.
`define AXI_ID   4'h3   // Fixed ID for every burst.
`define AXI_LEN  8'd7   // Eight beats, encoded as len + 1.
`define AXI_SIZE 3'd2   // 4-byte beats.

`define REQ_DEPTH 4     // Request FIFO entries.
`define RET_DEPTH 4     // Return FIFO entries, also the initial credit count.
`define CREDIT_W  3     // Credit counter width.

`endif
